//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release shortly after an edge, away from the sampling point
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;
    end

endmodule

//--- dv/tb_cnn_top.sv
`timescale 1ns/1ns

module tb_cnn_top import cnn_pkg::*; ();

    localparam int IX            = 8;
    localparam int IY            = 8;
    localparam int N_IMAGES      = 3;
    localparam int TOTAL         = IX * IY;
    localparam int N_RESULTS     = (IX - 2) * (IY - 2);
    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int FRAME_TIMEOUT = 2 * TOTAL + 40;
    localparam int WATCHDOG_NS   = 6 * (TOTAL + 40) * CLK_PERIOD * 4;
    localparam logic [31:0] LFSR_SEED = 32'h5f7a_407a;

    logic      clk;
    logic      por_n;
    logic      mid_reset;
    logic      reset_n;
    logic      start;
    logic [3:0] sel;
    load_req_t load;
    pix_beat_t result;
    logic      frame_done;

    // private copy of every image written into the DUT
    pixel_t      img_copy [N_IMAGES][TOTAL];
    int          exp_q [$];
    logic [31:0] lfsr_state;

    int check_count = 0;
    int err_count   = 0;
    int got_count   = 0;
    int done_count  = 0;
    int tests_run   = 0;
    int tests_bad   = 0;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) i_clock_gen (
        .clk     (clk),
        .reset_n (por_n)
    );

    assign reset_n = por_n && !mid_reset;

    cnn_top #(
        .IX       (IX),
        .IY       (IY),
        .N_IMAGES (N_IMAGES)
    ) i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .sel        (sel),
        .load       (load),
        .result     (result),
        .frame_done (frame_done)
    );

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t v;
        v = '0;
        for (int b = 0; b < PIXEL_W; b++) begin
            v = {v[PIXEL_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // images past N_IMAGES read as black
    function automatic int pixel_at(input int idx, input int r, input int c);
        if (idx >= N_IMAGES) begin
            return 0;
        end
        return int'(img_copy[idx][r * IX + c]);
    endfunction

    // window whose newest pixel sits at row r, column c
    function automatic int expected_result(input int idx, input int r, input int c);
        int acc;
        int w;
        acc = 0;
        for (int i = 0; i < 9; i++) begin
            w = KERNEL[i];
            acc += pixel_at(idx, r - 2 + i / 3, c - 2 + i % 3) * w;
        end
        if (acc < 0) begin
            acc = 0;
        end
        acc = acc >> OUT_SHIFT;
        if (acc > (1 << PIXEL_W) - 1) begin
            acc = (1 << PIXEL_W) - 1;
        end
        return acc;
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_image(input int idx, input bit flat, input pixel_t flat_val);
        pixel_t v;
        for (int a = 0; a < TOTAL; a++) begin
            v = flat ? flat_val : random_pixel();
            step();
            load = '{en: 1'b1, image: IMAGE_W'(idx), addr: LOAD_AW'(a), data: v};
            img_copy[idx][a] = v;
        end
        step();
        load = '0;
    endtask

    task automatic queue_frame(input int idx);
        for (int r = 2; r < IY; r++) begin
            for (int c = 2; c < IX; c++) begin
                exp_q.push_back(expected_result(idx, r, c));
            end
        end
    endtask

    // sel moves away right after the pulse so only the captured index counts
    task automatic pulse_start(input int idx);
        step();
        start = 1'b1;
        sel   = 4'(idx);
        step();
        start = 1'b0;
        sel   = 4'(idx + 1);
    endtask

    task automatic run_frame(input int idx, input bit extra_starts);
        int done_before;
        int got_before;
        int cyc;
        done_before = done_count;
        got_before  = got_count;
        queue_frame(idx);
        pulse_start(idx);
        cyc = 0;
        while (done_count == done_before && cyc < FRAME_TIMEOUT) begin
            step();
            start = extra_starts && (cyc == 10 || cyc == 30);
            cyc++;
        end
        start = 1'b0;
        if (done_count == done_before) begin
            err_count++;
            $display("no frame_done within %0d cycles of start, image %0d", FRAME_TIMEOUT, idx);
        end
        // long quiet period after ignored starts shows no second frame
        repeat (extra_starts ? TOTAL + 20 : 4) step();
        check_count += 3;
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d expected results never arrived for image %0d", exp_q.size(), idx);
        end
        if (got_count - got_before != N_RESULTS) begin
            err_count++;
            $display("received %0d results for image %0d instead of %0d",
                     got_count - got_before, idx, N_RESULTS);
        end
        if (done_count - done_before != 1) begin
            err_count++;
            $display("frame_done pulsed %0d times for image %0d instead of once",
                     done_count - done_before, idx);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests_run++;
        if (err_count != err_before) begin
            tests_bad++;
        end
        $display("test %0d %s: %s (%0d errors)", num, name,
                 (err_count == err_before) ? "pass" : "fail", err_count - err_before);
    endtask

    // compare process samples at the falling edge
    always @(negedge clk) begin
        int   exp_val;
        logic exp_done;
        exp_done = 1'b0;
        if (!reset_n) begin
            check_count++;
            if (result.valid || frame_done) begin
                err_count++;
                $display("FAIL %0t: result.valid or frame_done high during reset", $time);
            end
        end else begin
            if (frame_done) begin
                done_count++;
            end
            if (result.valid) begin
                got_count++;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("result beat at %0t with no expected value pending", $time);
                end else begin
                    exp_val  = exp_q.pop_front();
                    exp_done = (exp_q.size() == 0);
                    check_count += 2;
                    if (result.pixel !== pixel_t'(exp_val)) begin
                        err_count++;
                        $display("FAIL %0t: result pixel %0d, expected %0d",
                                 $time, result.pixel, exp_val);
                    end
                    if (result.last !== exp_done) begin
                        err_count++;
                        $display("FAIL %0t: result last %0b, expected %0b",
                                 $time, result.last, exp_done);
                    end
                end
            end
            // frame_done belongs to the final result beat of a frame
            check_count++;
            if (frame_done !== exp_done) begin
                err_count++;
                $display("FAIL %0t: frame_done %0b, expected %0b",
                         $time, frame_done, exp_done);
            end
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int err_before;
        int got_before;
        int cyc;
        start      = 1'b0;
        sel        = '0;
        load       = '0;
        mid_reset  = 1'b0;
        lfsr_state = LFSR_SEED;
        wait (reset_n === 1'b1);
        step();

        err_before = err_count;
        for (int k = 0; k < N_IMAGES; k++) begin
            load_image(k, 1'b0, '0);
        end
        run_frame(0, 1'b0);
        report_test(1, "random image 0", err_before);

        err_before = err_count;
        load_image(2, 1'b1, 8'hff);
        run_frame(1, 1'b0);
        run_frame(2, 1'b0);
        report_test(2, "images 1 and 2 back to back", err_before);

        err_before = err_count;
        run_frame(3, 1'b0);
        report_test(3, "index beyond N_IMAGES", err_before);

        err_before = err_count;
        run_frame(1, 1'b1);
        report_test(4, "start pulses while busy", err_before);

        // abort a frame once a few results are out
        err_before = err_count;
        got_before = got_count;
        queue_frame(0);
        pulse_start(0);
        cyc = 0;
        while (got_count - got_before < 5 && cyc < FRAME_TIMEOUT) begin
            step();
            cyc++;
        end
        if (got_count - got_before < 5) begin
            err_count++;
            $display("no results seen before the mid-frame reset");
        end
        mid_reset = 1'b1;
        repeat (3) step();
        exp_q.delete();
        mid_reset = 1'b0;
        repeat (2) step();
        run_frame(0, 1'b0);
        report_test(5, "reset in mid frame", err_before);

        $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/cnn_pkg.sv
rtl/fmap_feeder.sv
rtl/conv_window.sv
rtl/conv3x3_pe.sv
rtl/cnn_top.sv
dv/tb_clock_gen.sv
dv/tb_cnn_top.sv

//--- rtl/cnn_pkg.sv
package cnn_pkg;

    // pixel and accumulator widths
    localparam int PIXEL_W = 8;
    localparam int ACC_W   = 16;

    // load port field widths, 16 images of up to 1024 pixels
    localparam int IMAGE_W = 4;
    localparam int LOAD_AW = 10;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic signed [3:0]  weight_t;

    // row-major, index 0 is the oldest row and oldest column
    // weights sum to 11, so a flat 255 image clips at the output
    localparam weight_t KERNEL [9] = '{
        -4'sd1,  4'sd2, -4'sd1,
         4'sd2,  4'sd7,  4'sd2,
        -4'sd1,  4'sd2, -4'sd1
    };

    // right shift after relu
    localparam int OUT_SHIFT = 3;

    // one write into the image memory
    typedef struct packed {
        logic               en;
        logic [IMAGE_W-1:0] image;
        logic [LOAD_AW-1:0] addr;
        pixel_t             data;
    } load_req_t;

    typedef struct packed {
        logic   valid;
        logic   last;
        pixel_t pixel;
    } pix_beat_t;

    // px[0] oldest row/col, px[8] newest pixel
    typedef struct packed {
        logic         valid;
        logic         last;
        pixel_t [8:0] px;
    } window_t;

endpackage

//--- rtl/cnn_top.sv
`timescale 1ns/1ns

module cnn_top import cnn_pkg::*; #(
    parameter int IX       = 28,
    parameter int IY       = 28,
    parameter int N_IMAGES = 12
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start,
    input  logic [3:0] sel,
    input  load_req_t  load,
    output pix_beat_t  result,
    output logic       frame_done
);

    // raster pixel stream from image memory
    pix_beat_t pix;
    // complete 3x3 neighbourhoods only
    window_t   win;

    fmap_feeder #(
        .IX       (IX),
        .IY       (IY),
        .N_IMAGES (N_IMAGES)
    ) i_fmap_feeder (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .sel     (sel),
        .load    (load),
        .pix     (pix)
    );

    conv_window #(
        .IX (IX),
        .IY (IY)
    ) i_conv_window (
        .clk     (clk),
        .reset_n (reset_n),
        .pix     (pix),
        .win     (win)
    );

    // fixed kernel from the package
    conv3x3_pe i_conv3x3_pe (
        .clk        (clk),
        .reset_n    (reset_n),
        .win        (win),
        .result     (result),
        .frame_done (frame_done)
    );

endmodule

//--- rtl/conv3x3_pe.sv
`timescale 1ns/1ns

module conv3x3_pe import cnn_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  window_t   win,
    output pix_beat_t result,
    output logic      frame_done
);

    localparam logic [ACC_W-1:0] PIX_MAX = ACC_W'({PIXEL_W{1'b1}});

    logic signed [ACC_W-1:0] acc_c;
    logic signed [ACC_W-1:0] acc_q;
    logic                    s1_valid;
    logic                    s1_last;

    logic [ACC_W-1:0] relu;
    logic [ACC_W-1:0] shifted;
    pixel_t           sat;

    pixel_t res_pixel;
    logic   res_valid;
    logic   res_last;

    // stage 1: nine signed products summed
    always_comb begin
        logic signed [ACC_W-1:0] pix_s;
        logic signed [ACC_W-1:0] wgt_s;
        acc_c = '0;
        for (int i = 0; i < 9; i++) begin
            // pixel is unsigned, zero extend
            pix_s = ACC_W'(win.px[i]);
            wgt_s = ACC_W'(KERNEL[i]);
            acc_c = acc_c + pix_s * wgt_s;
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            acc_q <= acc_c;
        end
    end

    // stage 2: relu, scale down, clip to pixel range
    always_comb begin
        relu    = acc_q[ACC_W-1] ? '0 : unsigned'(acc_q);
        shifted = relu >> OUT_SHIFT;
        sat     = (shifted > PIX_MAX) ? PIX_MAX[PIXEL_W-1:0] : shifted[PIXEL_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res_pixel <= sat;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            res_valid  <= 1'b0;
            res_last   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            s1_valid   <= win.valid;
            s1_last    <= win.valid && win.last;
            res_valid  <= s1_valid;
            res_last   <= s1_valid && s1_last;
            // pulses with the final result beat
            frame_done <= s1_valid && s1_last;
        end
    end

    assign result = '{valid: res_valid, last: res_last, pixel: res_pixel};

endmodule

//--- rtl/conv_window.sv
`timescale 1ns/1ns

module conv_window import cnn_pkg::*; #(
    parameter int IX = 28,
    parameter int IY = 28
) (
    input  logic      clk,
    input  logic      reset_n,
    input  pix_beat_t pix,
    output window_t   win
);

    localparam int CW = $clog2(IX);
    localparam int RW = $clog2(IY);

    localparam logic [CW-1:0] COL_LAST = CW'(IX - 1);

    // one and two rows of delay, addressed by column
    pixel_t line_buf_1 [IX];
    pixel_t line_buf_2 [IX];

    logic [CW-1:0] col;
    logic [RW-1:0] row;

    pixel_t       tap_row0;
    pixel_t       tap_row1;
    logic         full_win;
    pixel_t [8:0] px_q;
    logic         win_valid;
    logic         win_last;

    // pixels from the same column two rows and one row up
    assign tap_row0 = line_buf_2[col];
    assign tap_row1 = line_buf_1[col];

    // window covers only real pixels once both counters reach 2
    assign full_win = (col >= CW'(2)) && (row >= RW'(2));

    always_ff @(posedge clk) begin
        if (pix.valid) begin
            line_buf_1[col] <= pix.pixel;
            line_buf_2[col] <= tap_row1;
            // shift window one column left per row
            for (int r = 0; r < 3; r++) begin
                px_q[r*3]     <= px_q[r*3 + 1];
                px_q[r*3 + 1] <= px_q[r*3 + 2];
            end
            // newest column enters on the right
            px_q[2] <= tap_row0;
            px_q[5] <= tap_row1;
            px_q[8] <= pix.pixel;
        end
    end

    // raster position of the incoming beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (pix.valid) begin
            if (pix.last) begin
                col <= '0;
                row <= '0;
            end else if (col == COL_LAST) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= pix.valid && full_win;
            win_last  <= pix.valid && full_win && pix.last;
        end
    end

    assign win = '{valid: win_valid, last: win_last, px: px_q};

endmodule

//--- rtl/fmap_feeder.sv
`timescale 1ns/1ns

module fmap_feeder import cnn_pkg::*; #(
    parameter int IX       = 28,
    parameter int IY       = 28,
    parameter int N_IMAGES = 12
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start,
    input  logic [3:0] sel,
    input  load_req_t  load,
    output pix_beat_t  pix
);

    localparam int TOTAL = IX * IY;
    localparam int DEPTH = N_IMAGES * TOTAL;
    // address counter runs one past the last pixel
    localparam int AW    = $clog2(TOTAL + 1);
    localparam int MW    = $clog2(DEPTH);

    localparam logic [AW-1:0] LAST_ADDR = AW'(TOTAL - 1);
    localparam logic [AW-1:0] END_ADDR  = AW'(TOTAL);

    typedef enum logic [1:0] {
        IDLE,
        SENDING,
        DONE
    } state_t;

    // all images back to back, image k starts at k*TOTAL
    pixel_t mem [DEPTH];

    state_t        state, state_next;
    logic [AW-1:0] addr_reg, addr_next;
    logic [3:0]    sel_reg, sel_next;
    logic          valid_reg, valid_next;
    logic          last_reg, last_next;
    pixel_t        pixel_reg;

    logic          wr_ok;
    logic [MW-1:0] wr_index;
    logic [MW-1:0] rd_index;
    logic          sel_ok;
    pixel_t        rd_pixel;
    logic          emit;

    // load port, out of range writes are dropped
    assign wr_ok    = load.en && (load.image < N_IMAGES) && (load.addr < TOTAL);
    assign wr_index = MW'(int'(load.image) * TOTAL + int'(load.addr));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_index] <= load.data;
        end
    end

    // unknown image index reads as black
    assign sel_ok   = sel_reg < N_IMAGES;
    assign rd_index = MW'(int'(sel_reg) * TOTAL + int'(addr_reg));
    assign rd_pixel = sel_ok ? mem[rd_index] : '0;

    assign emit = (state == SENDING) && (addr_reg < END_ADDR);

    always_comb begin
        state_next = state;
        addr_next  = addr_reg;
        sel_next   = sel_reg;
        valid_next = 1'b0;
        last_next  = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = SENDING;
                    sel_next   = sel;
                    addr_next  = '0;
                end
            end
            SENDING: begin
                if (emit) begin
                    valid_next = 1'b1;
                    last_next  = addr_reg == LAST_ADDR;
                    addr_next  = addr_reg + 1'b1;
                end else begin
                    addr_next  = '0;
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            addr_reg  <= '0;
            sel_reg   <= '0;
            valid_reg <= 1'b0;
            last_reg  <= 1'b0;
        end else begin
            state     <= state_next;
            addr_reg  <= addr_next;
            sel_reg   <= sel_next;
            valid_reg <= valid_next;
            last_reg  <= last_next;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            pixel_reg <= rd_pixel;
        end
    end

    assign pix = '{valid: valid_reg, last: last_reg, pixel: pixel_reg};

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and scan sim.log for the verdict
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cnn_top -f project.f \
    -o tb_cnn_top > sim.log 2>&1 &&
    ./obj_dir/tb_cnn_top >> sim.log 2>&1 ||
    { cat sim.log; echo "build or run error, see sim.log"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0
